// File: stile_pkg.sv
// Super-tile shared definitions
`default_nettype none

package stile_pkg;

  // Activation buffer geometry
  localparam int ACT_DATA_W  = 8;
  localparam int ACT_ADDR_W  = 7;                    // 128 words
  localparam int ACT_ADDRH_W = ACT_ADDR_W - 1;       // Word-pair address
  localparam int ACT_DEPTH   = 1 << ACT_ADDR_W;

  // Weight buffer geometry
  localparam int WBUF_DATA_W = 16;
  localparam int WBUF_ADDR_W = 10;                   // 1024 words
  localparam int WBUF_DEPTH  = 1 << WBUF_ADDR_W;

  // Multiplier and accumulator widths
  localparam int MUL_A_W = 30;                       // Weight side
  localparam int MUL_B_W = 18;                       // Activation side
  localparam int PSUM_W  = 48;

  // Pipeline depths
  localparam int WBUF_RD_LAT = 2;                    // Read register plus output register
  localparam int MAC_LAT     = 2;                    // Operand regs to psum register

  typedef logic [ACT_DATA_W-1:0]  act_word_t;
  typedef logic [WBUF_DATA_W-1:0] weight_t;
  typedef logic [PSUM_W-1:0]      psum_t;

  // Activation pair write, data[0] lands at the even address
  typedef struct packed {
    logic                   en;
    logic [ACT_ADDRH_W-1:0] addrh;
    act_word_t [1:0]        data;
  } act_wr_t;

  // Activation read, incr only applies in phase 1
  typedef struct packed {
    logic [ACT_ADDR_W-1:0] addr;
    logic [ACT_ADDR_W-1:0] incr;
  } act_rd_t;

  typedef struct packed {
    logic                   en;
    logic [WBUF_ADDR_W-1:0] addr;
    weight_t                data;
  } wbuf_wr_t;

endpackage

`default_nettype wire

// File: act_buffer.sv
// Activation buffer
`timescale 1ns/10ps
`default_nettype none

module act_buffer (
  input  logic                 clk_h,
  input  logic                 rst_n,
  input  stile_pkg::act_wr_t   wr,
  input  stile_pkg::act_rd_t   rd,
  output stile_pkg::act_word_t rd_data
);

  // Word storage
  stile_pkg::act_word_t mem [stile_pkg::ACT_DEPTH];

  logic                             phase_q;   // 0 low word / base, 1 high word / base+incr
  stile_pkg::act_word_t             wr_word;
  logic [stile_pkg::ACT_ADDR_W-1:0] wr_addr;
  logic [stile_pkg::ACT_ADDR_W-1:0] rd_addr;

  // Phase starts at 1 so the first edge after reset is a phase-1 edge
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= 1'b1;
    end else begin
      phase_q <= ~phase_q;
    end
  end

  // Phase picks the half of the pair and the low address bit
  assign wr_word = phase_q ? wr.data[1] : wr.data[0];
  assign wr_addr = {wr.addrh, phase_q};

  // Second read of the pair is offset by incr
  assign rd_addr = phase_q ? (rd.addr + rd.incr) : rd.addr;

  always_ff @(posedge clk_h) begin
    if (wr.en) begin
      mem[wr_addr] <= wr_word;                 // One word per edge
    end
  end

  assign rd_data = mem[rd_addr];               // Combinational read, zero latency

  // A wrap of the offset read would alias to low words
  a_no_wrap : assert property (
    @(posedge clk_h) disable iff (!rst_n)
      phase_q |-> (({1'b0, rd.addr} + {1'b0, rd.incr}) < stile_pkg::ACT_DEPTH)
  );

endmodule

`default_nettype wire

// File: weight_buffer.sv
// Weight buffer
`timescale 1ns/10ps
`default_nettype none

module weight_buffer (
  input  logic                              clk_h,
  input  logic                              rst_n,
  input  stile_pkg::wbuf_wr_t               wr,
  input  logic [stile_pkg::WBUF_ADDR_W-1:0] rd_addr,
  output stile_pkg::weight_t                rd_data
);

  // Array and first read stage
  stile_pkg::weight_t mem [stile_pkg::WBUF_DEPTH];
  stile_pkg::weight_t rd_q;

  // Output stages after the read register
  stile_pkg::weight_t out_q [stile_pkg::WBUF_RD_LAT-1];

  // Read sees the old word on a same-address write
  always_ff @(posedge clk_h) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    rd_q <= mem[rd_addr];                      // Read-first
  end

  // Output register chain
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < stile_pkg::WBUF_RD_LAT - 1; i++) begin
        out_q[i] <= '0;
      end
    end else begin
      out_q[0] <= rd_q;
      for (int i = 1; i < stile_pkg::WBUF_RD_LAT - 1; i++) begin
        out_q[i] <= out_q[i-1];                // Extra stages when latency grows
      end
    end
  end

  assign rd_data = out_q[stile_pkg::WBUF_RD_LAT-2];

endmodule

`default_nettype wire

// File: operand_skew.sv
// Multiplier operand skew
`timescale 1ns/10ps
`default_nettype none

module operand_skew #(
  parameter int ODD_TILE = 0                   // 1 on odd-indexed tiles
) (
  input  logic                          clk_h,
  input  logic                          rst_n,
  input  stile_pkg::weight_t            weight,
  input  stile_pkg::act_word_t          act,
  output logic [stile_pkg::MUL_A_W-1:0] mul_a,
  output logic [stile_pkg::MUL_B_W-1:0] mul_b
);

  logic [stile_pkg::MUL_A_W-1:0] a_ext;
  logic [stile_pkg::MUL_B_W-1:0] b_ext;

  // Unsigned operands, zero-extend to the multiplier ports
  assign a_ext = {{(stile_pkg::MUL_A_W - stile_pkg::WBUF_DATA_W){1'b0}}, weight};
  assign b_ext = {{(stile_pkg::MUL_B_W - stile_pkg::ACT_DATA_W){1'b0}}, act};

  if (ODD_TILE != 0) begin : g_odd
    logic [stile_pkg::MUL_A_W-1:0] a_q;
    logic [stile_pkg::MUL_B_W-1:0] b_q;

    // One extra cycle on both operands keeps them aligned
    always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
        a_q <= '0;
        b_q <= '0;
      end else begin
        a_q <= a_ext;
        b_q <= b_ext;
      end
    end

    assign mul_a = a_q;
    assign mul_b = b_q;
  end else begin : g_even
    assign mul_a = a_ext;                      // No skew on even tiles
    assign mul_b = b_ext;
  end

endmodule

`default_nettype wire

// File: mac_slice.sv
// Multiply and cascade accumulate
`timescale 1ns/10ps
`default_nettype none

module mac_slice (
  input  logic                          clk_h,
  input  logic                          rst_n,
  input  logic [stile_pkg::MUL_A_W-1:0] mul_a,
  input  logic [stile_pkg::MUL_B_W-1:0] mul_b,
  input  stile_pkg::psum_t              psum_casin,
  output stile_pkg::psum_t              psum_out,
  output stile_pkg::psum_t              psum_casout
);

  logic [stile_pkg::MUL_A_W-1:0] a_q;          // Operand registers
  logic [stile_pkg::MUL_B_W-1:0] b_q;
  stile_pkg::psum_t              prod_q;       // Product register
  stile_pkg::psum_t              psum_q;       // Partial-sum register
  logic [stile_pkg::PSUM_W:0]    sum_full;     // Sum with carry out

  // Cascade add with a carry bit for the overflow check
  assign sum_full = {1'b0, prod_q} + {1'b0, psum_casin};

  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      psum_q <= '0;
    end else begin
      a_q    <= mul_a;
      b_q    <= mul_b;
      prod_q <= a_q * b_q;                     // 30x18 fills 48 bits exactly
      psum_q <= sum_full[stile_pkg::PSUM_W-1:0];
    end
  end

  // Same register feeds the output and the next tile
  assign psum_out    = psum_q;
  assign psum_casout = psum_q;

  // Product plus cascade must fit the partial-sum width
  a_psum_fits : assert property (
    @(posedge clk_h) disable iff (!rst_n)
      !sum_full[stile_pkg::PSUM_W]
  );

  // Pipeline flushed with known values two edges after reset release
  a_psum_known : assert property (
    @(posedge clk_h) disable iff (!rst_n)
      $past(rst_n, stile_pkg::MAC_LAT) |-> !$isunknown(psum_out)
  );

endmodule

`default_nettype wire

// File: super_tile.sv
// Convolution super-tile
`timescale 1ns/10ps
`default_nettype none

module super_tile #(
  parameter int ODD_TILE = 0                   // 1 on odd-indexed tiles
) (
  input  logic                              clk_h,
  input  logic                              rst_n,
  input  stile_pkg::act_wr_t                act_wr,
  input  stile_pkg::act_rd_t                act_rd,
  input  stile_pkg::wbuf_wr_t               wbuf_wr,
  input  logic [stile_pkg::WBUF_ADDR_W-1:0] wbuf_rd_addr,
  input  stile_pkg::psum_t                  psum_casin,
  output stile_pkg::psum_t                  psum_out,
  output stile_pkg::psum_t                  psum_casout
);

  stile_pkg::act_word_t          act_rd_data;  // Same cycle as act_rd
  stile_pkg::weight_t            wbuf_rd_data; // Two edges after wbuf_rd_addr
  logic [stile_pkg::MUL_A_W-1:0] mul_a;
  logic [stile_pkg::MUL_B_W-1:0] mul_b;

  act_buffer u_act_buf (
    .clk_h   (clk_h),
    .rst_n   (rst_n),
    .wr      (act_wr),
    .rd      (act_rd),
    .rd_data (act_rd_data)
  );

  weight_buffer u_wbuf (
    .clk_h   (clk_h),
    .rst_n   (rst_n),
    .wr      (wbuf_wr),
    .rd_addr (wbuf_rd_addr),
    .rd_data (wbuf_rd_data)
  );

  operand_skew #(
    .ODD_TILE (ODD_TILE)
  ) u_skew (
    .clk_h  (clk_h),
    .rst_n  (rst_n),
    .weight (wbuf_rd_data),
    .act    (act_rd_data),
    .mul_a  (mul_a),
    .mul_b  (mul_b)
  );

  mac_slice u_mac (
    .clk_h       (clk_h),
    .rst_n       (rst_n),
    .mul_a       (mul_a),
    .mul_b       (mul_b),
    .psum_casin  (psum_casin),
    .psum_out    (psum_out),
    .psum_casout (psum_casout)
  );

endmodule

`default_nettype wire

// File: tb_super_tile.sv
// Super-tile testbench
`timescale 1ns/10ps
`default_nettype none

module tb_super_tile;

  localparam int MAX_SLOTS     = 1024;
  localparam int ODD_TILE      = 1;
  localparam int PRE_LAT       = stile_pkg::WBUF_RD_LAT;         // Weight address leads act read
  localparam int POST_LAT      = stile_pkg::MAC_LAT + ODD_TILE;  // Act read to psum_out
  localparam int IDLE_ACT_ADDR = 1;                              // Preloaded with zero in reset

  logic                              clk_h;
  logic                              rst_n;
  stile_pkg::act_wr_t                act_wr;
  stile_pkg::act_rd_t                act_rd;
  stile_pkg::wbuf_wr_t               wbuf_wr;
  logic [stile_pkg::WBUF_ADDR_W-1:0] wbuf_rd_addr;
  stile_pkg::psum_t                  psum_casin;
  stile_pkg::psum_t                  psum_out;
  stile_pkg::psum_t                  psum_casout;

  // Slot k holds the inputs sampled at edge k after reset release
  stile_pkg::act_wr_t                sch_act_wr  [MAX_SLOTS];
  stile_pkg::act_rd_t                sch_act_rd  [MAX_SLOTS];
  stile_pkg::wbuf_wr_t               sch_wbuf_wr [MAX_SLOTS];
  logic [stile_pkg::WBUF_ADDR_W-1:0] sch_wbuf_rd [MAX_SLOTS];
  stile_pkg::psum_t                  sch_casin   [MAX_SLOTS];
  stile_pkg::psum_t                  sch_expect  [MAX_SLOTS];  // psum_out after edge k

  integer seed;
  int     psum_errs;
  int     cas_errs;
  int     other_errs;
  int     n_lines;        // Records in the tests file
  int     last_slot;
  int     cycle_limit;
  int     cycles;

  initial begin
    clk_h = 1'b0;
    forever #5 clk_h = ~clk_h;
  end

  super_tile #(
    .ODD_TILE (ODD_TILE)
  ) dut0 (
    .clk_h        (clk_h),
    .rst_n        (rst_n),
    .act_wr       (act_wr),
    .act_rd       (act_rd),
    .wbuf_wr      (wbuf_wr),
    .wbuf_rd_addr (wbuf_rd_addr),
    .psum_casin   (psum_casin),
    .psum_out     (psum_out),
    .psum_casout  (psum_casout)
  );

  // Odd edge count means a phase-1 edge, edge 1 is the first after release
  function automatic logic edge_phase(input int k);
    return (k % 2) == 1;
  endfunction

  // Idle slots read zero weight, write ports get random data with enables low
  task automatic clear_schedule();
    logic [31:0] rnd;
    for (int k = 0; k < MAX_SLOTS; k++) begin
      rnd = $random(seed);
      sch_act_wr[k].en    = 1'b0;
      sch_act_wr[k].addrh = rnd[5:0];
      sch_act_wr[k].data  = rnd[31:16];
      rnd = $random(seed);
      sch_wbuf_wr[k].en   = 1'b0;
      sch_wbuf_wr[k].addr = rnd[9:0];
      sch_wbuf_wr[k].data = rnd[31:16];
      sch_act_rd[k].addr  = IDLE_ACT_ADDR;
      sch_act_rd[k].incr  = '0;
      sch_wbuf_rd[k]      = '0;
      sch_casin[k]        = '0;
      sch_expect[k]       = '0;
    end
  endtask

  task automatic load_tests();
    int                                fd;
    int                                code;
    byte                               kind;
    string                             rest;
    int                                slot;
    int                                wr_end;    // First slot after the last write
    int                                rd_next;   // First free activation read slot
    logic [stile_pkg::WBUF_ADDR_W-1:0] waddr;
    stile_pkg::weight_t                wdata;
    logic [stile_pkg::ACT_ADDRH_W-1:0] addrh;
    stile_pkg::act_word_t              lo;
    stile_pkg::act_word_t              hi;
    logic [stile_pkg::ACT_ADDR_W-1:0]  base;
    logic [stile_pkg::ACT_ADDR_W-1:0]  incr;
    stile_pkg::psum_t                  cas0;
    stile_pkg::psum_t                  cas1;
    stile_pkg::psum_t                  exp0;
    stile_pkg::psum_t                  exp1;
    wr_end  = 1;
    rd_next = 1;
    fd = $fopen("stile_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open stile_tests.txt, no tests were run");
      other_errs++;
      return;
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      if (rd_next + 8 >= MAX_SLOTS || wr_end + 8 >= MAX_SLOTS) begin
        $display("Tests file is longer than the schedule can hold");
        other_errs++;
        break;
      end
      code = 0;
      slot = (wr_end > rd_next) ? wr_end : rd_next;  // Writes wait for pending reads
      if (kind == "#") begin
        code = $fgets(rest, fd);                      // Comment line
        continue;
      end else if (kind == "W") begin
        code = $fscanf(fd, "%h %h", waddr, wdata);
        sch_wbuf_wr[slot] = {1'b1, waddr, wdata};
        wr_end = slot + 1;
      end else if (kind == "A") begin
        code = $fscanf(fd, "%h %h %h", addrh, lo, hi) - 1;
        if (edge_phase(slot)) slot++;                 // Pair starts on a phase-0 edge
        sch_act_wr[slot]   = {1'b1, addrh, hi, lo};
        sch_act_wr[slot+1] = {1'b1, addrh, hi, lo};
        wr_end = slot + 2;
      end else if (kind == "M") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h", waddr, base, incr, cas0, cas1, exp0, exp1)
               - 5;
        slot = (wr_end + PRE_LAT > rd_next) ? wr_end + PRE_LAT : rd_next;
        if (edge_phase(slot)) slot++;                 // Base read in phase 0
        for (int i = 0; i < 2; i++) begin
          sch_wbuf_rd[slot-PRE_LAT+i] = waddr;        // Same weight for both reads
          sch_act_rd[slot+i]          = {base, incr};
        end
        sch_casin[slot+POST_LAT]    = cas0;
        sch_casin[slot+POST_LAT+1]  = cas1;
        sch_expect[slot+POST_LAT]   = exp0;
        sch_expect[slot+POST_LAT+1] = exp1;
        rd_next = slot + 2;
      end
      if (code != 2) begin
        $display("Bad or unknown record in stile_tests.txt after %0d records", n_lines);
        other_errs++;
        break;
      end
      n_lines++;
    end
    $fclose(fd);
    last_slot = ((wr_end > rd_next + POST_LAT) ? wr_end : rd_next + POST_LAT) + 2;
  endtask

  task automatic apply_slot(input int k);
    act_wr       = sch_act_wr[k];
    act_rd       = sch_act_rd[k];
    wbuf_wr      = sch_wbuf_wr[k];
    wbuf_rd_addr = sch_wbuf_rd[k];
    psum_casin   = sch_casin[k];
  endtask

  task automatic check_psum(input stile_pkg::psum_t expected);
    if (psum_out !== expected) begin
      $display("[ERROR] %0t psum_out: got %h, expected %h", $time, psum_out, expected);
      psum_errs++;
    end
  endtask

  task automatic check_cascade(input stile_pkg::psum_t expected);
    if (psum_casout !== expected) begin
      $display("[ERROR] %0t psum_casout: got %h, expected %h", $time, psum_casout, expected);
      cas_errs++;
    end
  endtask

  initial begin
    seed         = 32'h9076_b0e4;
    psum_errs    = 0;
    cas_errs     = 0;
    other_errs   = 0;
    n_lines      = 0;
    last_slot    = 1;
    rst_n        = 1'b0;
    act_wr       = '0;
    act_wr.en    = 1'b1;                 // Phase is 1 in reset, so this zeroes the idle word
    act_rd       = {7'(IDLE_ACT_ADDR), 7'd0};
    wbuf_wr      = '0;
    wbuf_wr.en   = 1'b1;                 // Weight 0 cleared for idle reads
    wbuf_rd_addr = '0;
    psum_casin   = '0;
    clear_schedule();
    load_tests();
    cycle_limit = 20 * n_lines + 50;
    repeat (8) @(posedge clk_h);
    #1;
    rst_n = 1'b1;
    check_psum('0);
    check_cascade('0);
    apply_slot(1);
    for (int k = 1; k < last_slot; k++) begin
      @(posedge clk_h);
      #1;
      check_psum(sch_expect[k]);         // Zero wherever no result is due
      check_cascade(sch_expect[k]);
      apply_slot(k + 1);
    end
    $display("Errors: %0d psum_out, %0d psum_casout, %0d other", psum_errs, cas_errs,
             other_errs);
    if (psum_errs + cas_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog on edges after reset release
  initial begin
    cycles = 0;
    wait (rst_n === 1'b1);
    while (cycles < cycle_limit) begin
      @(posedge clk_h);
      cycles++;
    end
    $display("Timeout, run did not end within %0d cycles", cycle_limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: stile_tests.txt
# Records: W waddr wdata | A addrh lo hi | M waddr base incr cas0 cas1 exp0 exp1
# All fields hex, weight 0 and activation pair 0 stay reserved for idle reads
W 001 0003
W 002 00ff
W 003 ffff
W 004 1234
W 005 8000
A 01 05 07
A 02 10 20
A 04 ff 80
A 05 0a 0b
A 07 33 44
# Back-to-back multiplies with increments 1, 5 and 2
M 001 02 01 000000000000 000000000000 00000000000f 000000000015
M 002 04 05 000000000100 000000001000 0000000010f0 000000008f80
M 003 08 02 00123456789a 000000abcdef 00123555779b 000000b5cde5
M 004 0e 01 000000000001 000000000002 00000003a05d 00000004d5d2
M 005 05 05 ffff00000000 000000000000 ffff00100000 000000050000
# Weight and activation rewrites
W 001 0010
M 001 03 00 000000000003 000000000000 000000000073 000000000070
M 001 04 0b 000000000005 000000000007 000000000105 000000000447
A 01 09 0c
M 002 02 01 000000000010 000000000020 000000000907 000000000c14

// File: verilog.f
stile_pkg.sv
act_buffer.sv
weight_buffer.sv
operand_skew.sv
mac_slice.sv
super_tile.sv
tb_super_tile.sv

// File: Bender.yml
package:
  name: super_tile

dependencies: {}

sources:
  - files:
      - stile_pkg.sv
      - act_buffer.sv
      - weight_buffer.sv
      - operand_skew.sv
      - mac_slice.sv
      - super_tile.sv
  - target: test
    files:
      - tb_super_tile.sv
